//--- Makefile
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := tb_glay_kernel_cu
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
glay_pkg.sv
glay_fifo.sv
glay_kernel_control.sv
glay_kernel_setup.sv
glay_request_arbiter.sv
glay_kernel_cu.sv
tb_glay_kernel_cu.sv

//--- glay_fifo.sv
module glay_fifo #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned DEPTH     = 4
) (
  input  logic     ap_clk        ,
  input  logic     control_areset,
  input  logic     push          ,
  input  payload_t push_data     ,
  input  logic     pop           ,
  output payload_t head_data     ,
  output logic     empty         ,
  output logic     full
);

  // Pointer and occupancy widths
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Pop of an empty queue is dropped
  assign do_pop  = pop && !empty;
  assign do_push = push && !full;

  assign empty     = (count == '0);
  assign full      = (count == CNT_W'(DEPTH));
  // Head is visible in the same cycle it is popped
  assign head_data = mem[rd_ptr];

  // Storage, written on push only
  always_ff @(posedge ap_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers and count
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule : glay_fifo

//--- glay_kernel_control.sv
module glay_kernel_control (
  input  logic                    ap_clk                 ,
  input  logic                    control_areset         ,
  input  logic                    ap_start               ,
  input  logic                    ap_continue            ,
  input  logic                    descriptor_valid       ,
  input  glay_pkg::addr_t         descriptor_base_addr   ,
  input  glay_pkg::vertex_count_t descriptor_vertex_count,
  input  logic                    setup_complete         ,
  output logic                    ap_idle                ,
  output logic                    ap_ready               ,
  output logic                    ap_done                ,
  output logic                    job_start              ,
  output glay_pkg::addr_t         job_base_addr          ,
  output glay_pkg::vertex_count_t job_vertex_count
);

  import glay_pkg::*;

  localparam int unsigned TIMER_W = $clog2(DONE_TIMEOUT_CYCLES + 1);

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_BUSY,
    CTRL_DONE,
    CTRL_WAIT
  } ctrl_state_t;

  ctrl_state_t        state;
  logic [TIMER_W-1:0] timer;
  logic               timer_expired;

  // Timer saturates at the threshold
  assign timer_expired = (timer == TIMER_W'(DONE_TIMEOUT_CYCLES));

  // --------------------------------------------------
  // Descriptor latch
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (descriptor_valid) begin
      job_base_addr    <= descriptor_base_addr;
      job_vertex_count <= descriptor_vertex_count;
    end
  end

  // --------------------------------------------------
  // Control FSM and done timer
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state     <= CTRL_IDLE;
      timer     <= '0;
      ap_idle   <= 1'b1;
      ap_ready  <= 1'b0;
      ap_done   <= 1'b0;
      job_start <= 1'b0;
    end else begin
      // Strobes default low
      ap_ready  <= 1'b0;
      ap_done   <= 1'b0;
      job_start <= 1'b0;
      case (state)
        CTRL_IDLE: begin
          // Start accepted only here, ignored while busy
          if (ap_start) begin
            state     <= CTRL_BUSY;
            timer     <= '0;
            ap_idle   <= 1'b0;
            ap_ready  <= 1'b1;
            job_start <= 1'b1;
          end
        end
        CTRL_BUSY: begin
          if (!timer_expired) begin
            timer <= timer + 1'b1;
          end else if (setup_complete) begin
            state <= CTRL_DONE;
          end
        end
        CTRL_DONE: begin
          // Single done pulse
          ap_done <= 1'b1;
          state   <= CTRL_WAIT;
        end
        CTRL_WAIT: begin
          if (ap_continue) begin
            ap_idle <= 1'b1;
            state   <= CTRL_IDLE;
          end
        end
        default: state <= CTRL_IDLE;
      endcase
    end
  end

  // Ready and done are separated by at least the timeout
  a_ready_done_exclusive : assert property (
    @(posedge ap_clk) disable iff (control_areset) !(ap_ready && ap_done)
  );

endmodule : glay_kernel_control

//--- glay_kernel_cu.sv
module glay_kernel_cu (
  input  logic                    ap_clk                 ,
  input  logic                    control_areset         ,
  input  logic                    ap_start               ,
  input  logic                    ap_continue            ,
  input  logic                    descriptor_valid       ,
  input  glay_pkg::addr_t         descriptor_base_addr   ,
  input  glay_pkg::vertex_count_t descriptor_vertex_count,
  input  logic                    ext_req_valid          ,
  input  glay_pkg::addr_t         ext_req_addr           ,
  input  logic                    mem_resp_valid         ,
  input  glay_pkg::data_t         mem_resp_data          ,
  output logic                    ap_idle                ,
  output logic                    ap_ready               ,
  output logic                    ap_done                ,
  output logic                    ext_resp_valid         ,
  output glay_pkg::data_t         ext_resp_data          ,
  output logic                    mem_req_valid          ,
  output glay_pkg::addr_t         mem_req_addr
);

  import glay_pkg::*;

  // Reset branches
  logic areset_control;
  logic areset_setup;
  logic areset_arbiter;

  // Registered outside inputs
  logic          ap_start_in;
  logic          ap_continue_in;
  logic          descriptor_valid_in;
  addr_t         descriptor_base_addr_in;
  vertex_count_t descriptor_vertex_count_in;
  logic          ext_req_valid_in;
  addr_t         ext_req_addr_in;
  logic          mem_resp_valid_in;
  data_t         mem_resp_data_in;

  // Block outputs ahead of the output registers
  logic  ctrl_ap_idle;
  logic  ctrl_ap_ready;
  logic  ctrl_ap_done;
  logic  arb_ext_resp_valid;
  data_t arb_ext_resp_data;
  logic  arb_mem_req_valid;
  addr_t arb_mem_req_addr;

  // Control to setup to arbiter
  logic          job_start;
  addr_t         job_base_addr;
  vertex_count_t job_vertex_count;
  logic          setup_complete;
  logic          setup_req_valid;
  addr_t         setup_req_addr;
  logic          setup_stall;
  logic          setup_resp_valid;

  // --------------------------------------------------
  // Reset fan-out
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    areset_control <= control_areset;
    areset_setup   <= control_areset;
    areset_arbiter <= control_areset;
  end

  // --------------------------------------------------
  // Input registers
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ap_start_in         <= 1'b0;
      ap_continue_in      <= 1'b0;
      descriptor_valid_in <= 1'b0;
    end else begin
      ap_start_in         <= ap_start;
      ap_continue_in      <= ap_continue;
      descriptor_valid_in <= descriptor_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_arbiter) begin
      ext_req_valid_in  <= 1'b0;
      mem_resp_valid_in <= 1'b0;
    end else begin
      ext_req_valid_in  <= ext_req_valid;
      mem_resp_valid_in <= mem_resp_valid;
    end
  end

  // Payloads follow their strobes
  always_ff @(posedge ap_clk) begin
    descriptor_base_addr_in    <= descriptor_base_addr;
    descriptor_vertex_count_in <= descriptor_vertex_count;
    ext_req_addr_in            <= ext_req_addr;
    mem_resp_data_in           <= mem_resp_data;
  end

  // --------------------------------------------------
  // Output registers
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ap_idle  <= 1'b1;
      ap_ready <= 1'b0;
      ap_done  <= 1'b0;
    end else begin
      ap_idle  <= ctrl_ap_idle;
      ap_ready <= ctrl_ap_ready;
      ap_done  <= ctrl_ap_done;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_arbiter) begin
      mem_req_valid  <= 1'b0;
      ext_resp_valid <= 1'b0;
    end else begin
      mem_req_valid  <= arb_mem_req_valid;
      ext_resp_valid <= arb_ext_resp_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    mem_req_addr  <= arb_mem_req_addr;
    ext_resp_data <= arb_ext_resp_data;
  end

  // --------------------------------------------------
  // Blocks
  // --------------------------------------------------
  glay_kernel_control u_control (
    .ap_clk                 (ap_clk                    ),
    .control_areset         (areset_control            ),
    .ap_start               (ap_start_in               ),
    .ap_continue            (ap_continue_in            ),
    .descriptor_valid       (descriptor_valid_in       ),
    .descriptor_base_addr   (descriptor_base_addr_in   ),
    .descriptor_vertex_count(descriptor_vertex_count_in),
    .setup_complete         (setup_complete            ),
    .ap_idle                (ctrl_ap_idle              ),
    .ap_ready               (ctrl_ap_ready             ),
    .ap_done                (ctrl_ap_done              ),
    .job_start              (job_start                 ),
    .job_base_addr          (job_base_addr             ),
    .job_vertex_count       (job_vertex_count          )
  );

  glay_kernel_setup u_setup (
    .ap_clk          (ap_clk          ),
    .control_areset  (areset_setup    ),
    .job_start       (job_start       ),
    .job_base_addr   (job_base_addr   ),
    .job_vertex_count(job_vertex_count),
    .setup_stall     (setup_stall     ),
    .setup_resp_valid(setup_resp_valid),
    .setup_req_valid (setup_req_valid ),
    .setup_req_addr  (setup_req_addr  ),
    .setup_complete  (setup_complete  )
  );

  glay_request_arbiter u_arbiter (
    .ap_clk          (ap_clk            ),
    .control_areset  (areset_arbiter    ),
    .setup_req_valid (setup_req_valid   ),
    .setup_req_addr  (setup_req_addr    ),
    .ext_req_valid   (ext_req_valid_in  ),
    .ext_req_addr    (ext_req_addr_in   ),
    .mem_resp_valid  (mem_resp_valid_in ),
    .mem_resp_data   (mem_resp_data_in  ),
    .setup_stall     (setup_stall       ),
    .setup_resp_valid(setup_resp_valid  ),
    .ext_resp_valid  (arb_ext_resp_valid),
    .ext_resp_data   (arb_ext_resp_data ),
    .mem_req_valid   (arb_mem_req_valid ),
    .mem_req_addr    (arb_mem_req_addr  )
  );

endmodule : glay_kernel_cu

//--- glay_kernel_setup.sv
module glay_kernel_setup (
  input  logic                    ap_clk          ,
  input  logic                    control_areset  ,
  input  logic                    job_start       ,
  input  glay_pkg::addr_t         job_base_addr   ,
  input  glay_pkg::vertex_count_t job_vertex_count,
  input  logic                    setup_stall     ,
  input  logic                    setup_resp_valid,
  output logic                    setup_req_valid ,
  output glay_pkg::addr_t         setup_req_addr  ,
  output logic                    setup_complete
);

  import glay_pkg::*;

  vertex_count_t total;
  vertex_count_t issued;
  vertex_count_t received;
  addr_t         next_addr;

  // Issue straight into queue 0 unless it is full
  assign setup_req_valid = (issued != total) && !setup_stall;
  assign setup_req_addr  = next_addr;

  // --------------------------------------------------
  // Address walk
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (job_start) begin
      next_addr <= job_base_addr;
    end else if (setup_req_valid) begin
      next_addr <= next_addr + addr_t'(VERTEX_BLOCK_BYTES);
    end
  end

  // --------------------------------------------------
  // Issue and response counters
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      total          <= '0;
      issued         <= '0;
      received       <= '0;
      setup_complete <= 1'b0;
    end else if (job_start) begin
      total          <= job_vertex_count;
      issued         <= '0;
      received       <= '0;
      // Empty job is complete at once
      setup_complete <= (job_vertex_count == '0);
    end else begin
      if (setup_req_valid) begin
        issued <= issued + 1'b1;
      end
      if (setup_resp_valid) begin
        received <= received + 1'b1;
        // Last response closes the job
        if (received == total - 1'b1) begin
          setup_complete <= 1'b1;
        end
      end
    end
  end

endmodule : glay_kernel_setup

//--- glay_pkg.sv
package glay_pkg;

  // --------------------------------------------------
  // Memory port widths
  // --------------------------------------------------
  // Byte address of a read
  typedef logic [31:0] addr_t;
  // Read data returned by memory
  typedef logic [63:0] data_t;
  // Vertex blocks in one job
  typedef logic [15:0] vertex_count_t;

  // --------------------------------------------------
  // Requestors
  // --------------------------------------------------
  // Setup is index 0, external port is index 1
  localparam int unsigned NUM_MEMORY_REQUESTOR = 2;

  typedef logic [$clog2(NUM_MEMORY_REQUESTOR)-1:0] requestor_id_t;

  localparam requestor_id_t REQ_ID_SETUP = 1'b0;
  localparam requestor_id_t REQ_ID_EXT   = 1'b1;

  // Read request, address only
  typedef struct packed {
    addr_t addr;
  } mem_request_t;

  // --------------------------------------------------
  // Sizing and timing
  // --------------------------------------------------
  // Reads in flight to memory, also id queue depth
  localparam int unsigned OUTSTANDING_MAX     = 8;
  // Entries per requestor queue
  localparam int unsigned REQ_QUEUE_DEPTH     = 4;
  // Busy cycles before done may assert
  localparam int unsigned DONE_TIMEOUT_CYCLES = 64;
  // Address step between setup reads
  localparam int unsigned VERTEX_BLOCK_BYTES  = 64;

endpackage : glay_pkg

//--- glay_request_arbiter.sv
module glay_request_arbiter (
  input  logic            ap_clk          ,
  input  logic            control_areset  ,
  input  logic            setup_req_valid ,
  input  glay_pkg::addr_t setup_req_addr  ,
  input  logic            ext_req_valid   ,
  input  glay_pkg::addr_t ext_req_addr    ,
  input  logic            mem_resp_valid  ,
  input  glay_pkg::data_t mem_resp_data   ,
  output logic            setup_stall     ,
  output logic            setup_resp_valid,
  output logic            ext_resp_valid  ,
  output glay_pkg::data_t ext_resp_data   ,
  output logic            mem_req_valid   ,
  output glay_pkg::addr_t mem_req_addr
);

  import glay_pkg::*;

  localparam int unsigned OUT_W = $clog2(OUTSTANDING_MAX + 1);

  mem_request_t     setup_req;
  mem_request_t     ext_req;
  mem_request_t     setup_head;
  mem_request_t     ext_head;
  mem_request_t     grant_head;
  logic             setup_empty;
  logic             ext_empty;
  logic             ext_full;
  logic             setup_pop;
  logic             ext_pop;
  logic             issue;
  requestor_id_t    rr_turn;
  requestor_id_t    grant;
  requestor_id_t    resp_id;
  logic             id_empty;
  logic             id_full;
  logic [OUT_W-1:0] outstanding;

  assign setup_req = '{addr: setup_req_addr};
  assign ext_req   = '{addr: ext_req_addr};

  // --------------------------------------------------
  // Per-requestor queues
  // --------------------------------------------------
  glay_fifo #(
    .payload_t(mem_request_t  ),
    .DEPTH    (REQ_QUEUE_DEPTH)
  ) u_setup_queue (
    .ap_clk        (ap_clk         ),
    .control_areset(control_areset ),
    .push          (setup_req_valid),
    .push_data     (setup_req      ),
    .pop           (setup_pop      ),
    .head_data     (setup_head     ),
    .empty         (setup_empty    ),
    .full          (setup_stall    )
  );

  glay_fifo #(
    .payload_t(mem_request_t  ),
    .DEPTH    (REQ_QUEUE_DEPTH)
  ) u_ext_queue (
    .ap_clk        (ap_clk        ),
    .control_areset(control_areset),
    .push          (ext_req_valid ),
    .push_data     (ext_req       ),
    .pop           (ext_pop       ),
    .head_data     (ext_head      ),
    .empty         (ext_empty     ),
    .full          (ext_full      )
  );

  // --------------------------------------------------
  // Round-robin pick and issue
  // --------------------------------------------------
  always_comb begin
    if (setup_empty) begin
      grant = REQ_ID_EXT;
    end else if (ext_empty) begin
      grant = REQ_ID_SETUP;
    end else begin
      grant = rr_turn;
    end
  end

  // Hold off when the in-flight window is full
  assign issue      = !(setup_empty && ext_empty) && (outstanding != OUT_W'(OUTSTANDING_MAX));
  assign setup_pop  = issue && (grant == REQ_ID_SETUP);
  assign ext_pop    = issue && (grant == REQ_ID_EXT);
  assign grant_head = (grant == REQ_ID_SETUP) ? setup_head : ext_head;

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      rr_turn       <= REQ_ID_SETUP;
      mem_req_valid <= 1'b0;
      outstanding   <= '0;
    end else begin
      mem_req_valid <= issue;
      // Turn passes to the other requestor
      if (issue) begin
        rr_turn <= requestor_id_t'(grant + 1'b1);
      end
      case ({issue, mem_resp_valid})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    if (issue) begin
      mem_req_addr <= grant_head.addr;
    end
  end

  // --------------------------------------------------
  // Response routing
  // --------------------------------------------------
  // Owner of each read, in issue order
  glay_fifo #(
    .payload_t(requestor_id_t ),
    .DEPTH    (OUTSTANDING_MAX)
  ) u_id_queue (
    .ap_clk        (ap_clk        ),
    .control_areset(control_areset),
    .push          (issue         ),
    .push_data     (grant         ),
    .pop           (mem_resp_valid),
    .head_data     (resp_id       ),
    .empty         (id_empty      ),
    .full          (id_full       )
  );

  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      setup_resp_valid <= 1'b0;
      ext_resp_valid   <= 1'b0;
    end else begin
      setup_resp_valid <= mem_resp_valid && (resp_id == REQ_ID_SETUP);
      ext_resp_valid   <= mem_resp_valid && (resp_id == REQ_ID_EXT);
    end
  end

  always_ff @(posedge ap_clk) begin
    ext_resp_data <= mem_resp_data;
  end

  // Memory answers only reads this block issued
  a_resp_has_owner : assert property (
    @(posedge ap_clk) disable iff (control_areset) mem_resp_valid |-> !id_empty
  );

  // Senders respect queue space
  a_no_push_when_full : assert property (
    @(posedge ap_clk) disable iff (control_areset)
      !(setup_req_valid && setup_stall) && !(ext_req_valid && ext_full) &&
      !(issue && id_full)
  );

endmodule : glay_request_arbiter

//--- tb_glay_kernel_cu.sv
module tb_glay_kernel_cu;

  import glay_pkg::*;

  localparam int NUM_TESTS = 5;

  // --------------------------------------------------
  // Test table
  // --------------------------------------------------
  // Setup bases stay below bit 31, external reads always set it
  string       row_name  [NUM_TESTS] = '{"basic_job", "empty_job", "long_delay",
                                         "ext_heavy", "setup_stall"};
  addr_t       row_base  [NUM_TESTS] = '{32'h0000_1000, 32'h0000_2000, 32'h0001_0000,
                                         32'h0002_0040, 32'h0003_0000};
  int unsigned row_count [NUM_TESTS] = '{4, 0, 48, 2, 20};
  int unsigned row_ext   [NUM_TESTS] = '{3, 2, 6, 10, 4};
  int unsigned row_delay [NUM_TESTS] = '{2, 1, 24, 4, 12};

  // DUT ports
  logic          ap_clk = 1'b0;
  logic          control_areset;
  logic          ap_start;
  logic          ap_continue;
  logic          descriptor_valid;
  addr_t         descriptor_base_addr;
  vertex_count_t descriptor_vertex_count;
  logic          ext_req_valid;
  addr_t         ext_req_addr;
  logic          mem_resp_valid = 1'b0;
  data_t         mem_resp_data  = '0;
  logic          ap_idle;
  logic          ap_ready;
  logic          ap_done;
  logic          ext_resp_valid;
  data_t         ext_resp_data;
  logic          mem_req_valid;
  addr_t         mem_req_addr;

  // Stimulus side state
  int          stim_seed = 32'h4b17_1559;
  int          cycle_count = 0;
  string       cur_test = "reset";
  addr_t       cur_base = '0;
  int unsigned cur_count = 0;
  int unsigned cur_max_delay = 0;
  int unsigned row_setup_start = 0;
  int unsigned row_resp_start = 0;
  int unsigned ext_expected_total = 0;
  int          main_errors = 0;
  addr_t       ext_sent_q [$];

  // Memory model and monitor state
  int          mem_seed = 32'h4b17_1559;
  int          monitor_errors = 0;
  int unsigned ext_issue_idx = 0;
  int unsigned setup_seen = 0;
  int unsigned setup_resp_seen = 0;
  int unsigned ext_resp_seen = 0;
  int unsigned ready_count = 0;
  int unsigned done_count = 0;
  int          issued_count = 0;
  int          resp_count = 0;
  int          last_setup_resp = 0;
  addr_t       pend_addr [$];
  int          pend_due  [$];
  data_t       ext_data_q [$];
  int          ext_due_q  [$];

  glay_kernel_cu u_dut (
    .ap_clk                 (ap_clk                 ),
    .control_areset         (control_areset         ),
    .ap_start               (ap_start               ),
    .ap_continue            (ap_continue            ),
    .descriptor_valid       (descriptor_valid       ),
    .descriptor_base_addr   (descriptor_base_addr   ),
    .descriptor_vertex_count(descriptor_vertex_count),
    .ext_req_valid          (ext_req_valid          ),
    .ext_req_addr           (ext_req_addr           ),
    .mem_resp_valid         (mem_resp_valid         ),
    .mem_resp_data          (mem_resp_data          ),
    .ap_idle                (ap_idle                ),
    .ap_ready               (ap_ready               ),
    .ap_done                (ap_done                ),
    .ext_resp_valid         (ext_resp_valid         ),
    .ext_resp_data          (ext_resp_data          ),
    .mem_req_valid          (mem_req_valid          ),
    .mem_req_addr           (mem_req_addr           )
  );

  always #5 ap_clk = ~ap_clk;

  // Edge index, read on the falling edge
  always @(posedge ap_clk) begin
    cycle_count <= cycle_count + 1;
  end

  // Memory contents, a fixed mix of the address
  function automatic data_t mem_word(input addr_t addr);
    return {addr ^ 32'hc3a5_5a3c, addr + 32'h1357_9bdf};
  endfunction

  task automatic report_mismatch(inout int errors, input string what,
                                 input logic [63:0] expected, input logic [63:0] actual);
    $display("Error: %s %s expected 0x%0h actual 0x%0h", cur_test, what, expected, actual);
    errors++;
  endtask

  task automatic report_problem(inout int errors, input string what);
    $display("%s: %s", cur_test, what);
    errors++;
  endtask

  // --------------------------------------------------
  // In-order memory model and output monitor
  // --------------------------------------------------
  always @(negedge ap_clk) begin : mem_model
    addr_t exp_addr;
    int    delay;
    if (!control_areset) begin
      if (mem_req_valid === 1'b1) begin
        issued_count++;
        if (mem_req_addr[31]) begin
          // External reads keep their send order
          if (ext_issue_idx >= ext_sent_q.size()) begin
            report_problem(monitor_errors, "external read issued that was never sent");
          end else if (mem_req_addr !== ext_sent_q[ext_issue_idx]) begin
            report_mismatch(monitor_errors, "ext mem_req_addr",
                            64'(ext_sent_q[ext_issue_idx]), 64'(mem_req_addr));
          end
          ext_issue_idx++;
        end else begin
          // Setup walks up from the base one block at a time
          exp_addr = cur_base + addr_t'((setup_seen - row_setup_start) * VERTEX_BLOCK_BYTES);
          if (setup_seen - row_setup_start >= cur_count) begin
            report_problem(monitor_errors, "setup issued more reads than the vertex count");
          end else if (mem_req_addr !== exp_addr) begin
            report_mismatch(monitor_errors, "setup mem_req_addr", 64'(exp_addr),
                            64'(mem_req_addr));
          end
          setup_seen++;
        end
        delay = int'(($random(mem_seed) & 32'h7fff_ffff) % (cur_max_delay + 1));
        pend_addr.push_back(mem_req_addr);
        pend_due.push_back(cycle_count + delay);
        if (issued_count - resp_count > int'(OUTSTANDING_MAX)) begin
          report_problem(monitor_errors, "more reads in flight than the outstanding limit");
        end
      end
      // One response per cycle, oldest first
      if (pend_addr.size() != 0 && pend_due[0] <= cycle_count) begin
        mem_resp_valid = 1'b1;
        mem_resp_data  = mem_word(pend_addr[0]);
        resp_count++;
        if (pend_addr[0][31]) begin
          ext_data_q.push_back(mem_word(pend_addr[0]));
          ext_due_q.push_back(cycle_count + 3);
        end else begin
          setup_resp_seen++;
          last_setup_resp = cycle_count;
        end
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end else begin
        mem_resp_valid = 1'b0;
      end
      // External responses come back three edges later
      if (ext_due_q.size() != 0 && ext_due_q[0] == cycle_count) begin
        if (ext_resp_valid !== 1'b1) begin
          report_problem(monitor_errors, "ext_resp_valid missing three edges after its response");
        end else if (ext_resp_data !== ext_data_q[0]) begin
          report_mismatch(monitor_errors, "ext_resp_data", ext_data_q[0], ext_resp_data);
        end
        void'(ext_due_q.pop_front());
        void'(ext_data_q.pop_front());
        ext_resp_seen++;
      end else if (ext_resp_valid === 1'b1) begin
        report_problem(monitor_errors, "ext_resp_valid with no external response due");
      end
      if (ap_ready === 1'b1) ready_count++;
      if (ap_done === 1'b1) done_count++;
    end
  end

  // --------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------
  // Random external strobes, never more than a queue ahead of the issues
  task send_ext_requests(input int unsigned total);
    int unsigned sent;
    int unsigned seen;
    int          rnd;
    addr_t       addr;
    sent = 0;
    seen = 0;
    while (sent < total) begin
      @(negedge ap_clk);
      if (mem_req_valid === 1'b1 && mem_req_addr[31]) seen++;
      rnd = $random(stim_seed);
      if ((sent - seen) < REQ_QUEUE_DEPTH && rnd[0]) begin
        addr = {1'b1, rnd[30:3], 3'b000};
        ext_sent_q.push_back(addr);
        ext_req_valid = 1'b1;
        ext_req_addr  = addr;
        sent++;
      end else begin
        ext_req_valid = 1'b0;
      end
    end
    @(negedge ap_clk);
    ext_req_valid = 1'b0;
  endtask

  task wait_for_done(output int done_at);
    do @(negedge ap_clk); while (ap_done !== 1'b1);
    done_at = cycle_count;
  endtask

  task run_job(input int i);
    int ready_at;
    int done_at;
    cur_test           = row_name[i];
    cur_base           = row_base[i];
    cur_count          = row_count[i];
    cur_max_delay      = row_delay[i];
    row_setup_start    = setup_seen;
    row_resp_start     = setup_resp_seen;
    ext_expected_total = ext_expected_total + row_ext[i];
    @(negedge ap_clk);
    descriptor_valid        = 1'b1;
    descriptor_base_addr    = row_base[i];
    descriptor_vertex_count = vertex_count_t'(row_count[i]);
    @(negedge ap_clk);
    descriptor_valid = 1'b0;
    ap_start         = 1'b1;
    @(negedge ap_clk);
    ap_start = 1'b0;
    // Ready and idle hold for two edges, then move together
    repeat (2) begin
      if (ap_ready !== 1'b0 || ap_idle !== 1'b1) begin
        report_problem(main_errors, "ap_ready or ap_idle moved before the third edge");
      end
      @(negedge ap_clk);
    end
    if (ap_ready !== 1'b1) report_mismatch(main_errors, "ap_ready", 64'd1, 64'(ap_ready));
    if (ap_idle !== 1'b0) report_mismatch(main_errors, "ap_idle", 64'd0, 64'(ap_idle));
    ready_at = cycle_count;
    // Start while busy
    @(negedge ap_clk);
    ap_start = 1'b1;
    @(negedge ap_clk);
    ap_start = 1'b0;
    fork
      send_ext_requests(row_ext[i]);
      wait_for_done(done_at);
    join
    // Drain memory and external responses
    do @(posedge ap_clk); while (ext_resp_seen < ext_expected_total || pend_addr.size() != 0);
    @(negedge ap_clk);
    if (ready_count != i + 1) report_mismatch(main_errors, "ap_ready pulses", 64'(i + 1),
                                              64'(ready_count));
    if (done_count != i + 1) report_mismatch(main_errors, "ap_done pulses", 64'(i + 1),
                                             64'(done_count));
    if (setup_seen - row_setup_start != row_count[i]) begin
      report_mismatch(main_errors, "setup reads", 64'(row_count[i]),
                      64'(setup_seen - row_setup_start));
    end
    if (setup_resp_seen - row_resp_start != row_count[i]) begin
      report_mismatch(main_errors, "setup responses", 64'(row_count[i]),
                      64'(setup_resp_seen - row_resp_start));
    end
    if (done_at - ready_at < int'(DONE_TIMEOUT_CYCLES)) begin
      report_problem(main_errors, "ap_done came before the done timer expired");
    end
    if (row_count[i] != 0 && last_setup_resp >= done_at) begin
      report_problem(main_errors, "ap_done came before the last setup response");
    end
    @(negedge ap_clk);
    ap_continue = 1'b1;
    @(negedge ap_clk);
    ap_continue = 1'b0;
    repeat (2) begin
      if (ap_idle !== 1'b0) report_problem(main_errors, "ap_idle rose before the third edge");
      @(negedge ap_clk);
    end
    if (ap_idle !== 1'b1) report_mismatch(main_errors, "ap_idle after continue", 64'd1,
                                          64'(ap_idle));
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin : stimulus
    control_areset          = 1'b1;
    ap_start                = 1'b0;
    ap_continue             = 1'b0;
    descriptor_valid        = 1'b0;
    descriptor_base_addr    = '0;
    descriptor_vertex_count = '0;
    ext_req_valid           = 1'b0;
    ext_req_addr            = '0;
    repeat (8) @(negedge ap_clk);
    control_areset = 1'b0;
    repeat (3) @(negedge ap_clk);
    if (ap_idle !== 1'b1) report_mismatch(main_errors, "ap_idle after reset", 64'd1, 64'(ap_idle));
    if ({ap_ready, ap_done, mem_req_valid, ext_resp_valid} !== 4'b0000) begin
      report_mismatch(main_errors, "strobes after reset", 64'd0,
                      64'({ap_ready, ap_done, mem_req_valid, ext_resp_valid}));
    end
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_job(i);
    end
    repeat (5) @(negedge ap_clk);
    $display("Tests run: %0d, stimulus errors: %0d, monitor errors: %0d",
             NUM_TESTS, main_errors, monitor_errors);
    if (main_errors + monitor_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Bound scales with the timer, the traffic and the response delay of each row
  initial begin : watchdog
    longint limit;
    limit = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      limit += longint'((DONE_TIMEOUT_CYCLES + row_count[i] + row_ext[i]) *
                        (row_delay[i] + 8)) * 10;
    end
    // Reset and closing cycles
    limit += 5000;
    #(limit);
    $display("Watchdog expired after %0d time units, the run did not finish", limit);
    $display("Test failed");
    $finish;
  end

endmodule : tb_glay_kernel_cu
